/* run.sh */
#!/bin/sh
# build and run the twiddle stage testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f twdl_stage.f --top-module twdl_stage_tb -o twdl_stage_sim; then
	echo "compile failed"
	exit 1
fi

if ! ./obj_dir/twdl_stage_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
exit 1

/* twdl_cfg_regs.sv */
`timescale 1ns/1ps

module twdl_cfg_regs import twdl_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic cfg_wr,
	input  cfg_t cfg_in,
	output cfg_t cfg,
	output logic cfg_err
);

	logic radix_ok;

	// supported radices only
	always_comb begin
		case (cfg_in.radix)
			3'd2, 3'd3, 3'd4, 3'd5: radix_ok = 1'b1;
			default: radix_ok = 1'b0;
		endcase
	end

	// radix 4 forward out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg.radix <= 3'd4;
			cfg.inverse <= 1'b0;
			cfg_err <= 1'b0;
		end else if (cfg_wr) begin
			if (radix_ok) begin
				cfg <= cfg_in;
				// good write clears the flag
				cfg_err <= 1'b0;
			end else begin
				// refused, old setting stays
				cfg_err <= 1'b1;
			end
		end
	end

	// sticky until next valid write

endmodule

/* twdl_cmult.sv */
`timescale 1ns/1ps

module twdl_cmult import twdl_pkg::*; #(
	parameter int data_w = twdl_pkg::data_w
) (
	input  logic  clk,
	input  logic  rst_n,
	input  cplx_t x,
	input  tw_t   w,
	output cplx_t y
);

	// data times Q2.14
	localparam int mul_w = data_w + tw_w;

	logic signed [mul_w-1:0]   p_rr;
	logic signed [mul_w-1:0]   p_ii;
	logic signed [mul_w-1:0]   p_ri;
	logic signed [mul_w-1:0]   p_ir;
	logic signed [prod_w-1:0]  acc_re;
	logic signed [prod_w-1:0]  acc_im;
	logic signed [prod_w-15:0] rnd_re;
	logic signed [prod_w-15:0] rnd_im;

	// cycle 1: four partial products
	always_ff @(posedge clk) begin
		p_rr <= x.re * w.re;
		p_ii <= x.im * w.im;
		p_ri <= x.re * w.im;
		p_ir <= x.im * w.re;
	end

	// (a+jb)(c+jd) = (ac-bd) + j(ad+bc)
	assign acc_re = p_rr - p_ii;
	assign acc_im = p_ri + p_ir;
	assign rnd_re = round_q14(acc_re);
	assign rnd_im = round_q14(acc_im);

	// cycle 2: rounded, wrapped to data width
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y <= '0;
		end else begin
			y.re <= rnd_re[data_w-1:0];
			y.im <= rnd_im[data_w-1:0];
		end
	end

endmodule

/* twdl_coeff_gen.sv */
`timescale 1ns/1ps

module twdl_coeff_gen import twdl_pkg::*; #(
	parameter int phase_w = twdl_pkg::phase_w
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [phase_w-1:0] phase,
	output tw_t                w1
);

	// offset inside one quadrant
	localparam int off_w = phase_w - 2;
	// quarter wave incl. both end points
	localparam int tab_n = (1 << off_w) + 1;

	logic signed [tw_w-1:0] rom [tab_n];
	logic [1:0]             quad;
	logic [off_w:0]         addr_cos;
	logic [off_w:0]         addr_sin;
	logic signed [tw_w-1:0] c;
	logic signed [tw_w-1:0] s;

	// cosine 0..pi/2 in Q2.14
	initial $readmemh("twdl_rom.hex", rom);

	// cycle 1: quadrant and both table addresses
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			quad <= 2'd0;
			addr_cos <= '0;
			addr_sin <= '0;
		end else begin
			quad <= phase[phase_w-1 -: 2];
			addr_cos <= {1'b0, phase[off_w-1:0]};
			// sin(x) = cos(pi/2 - x)
			addr_sin <= {1'b1, {off_w{1'b0}}} - {1'b0, phase[off_w-1:0]};
		end
	end

	assign c = rom[addr_cos];
	assign s = rom[addr_sin];

	// cycle 2: fold into w1 = cos - j*sin
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w1 <= '0;
		end else begin
			case (quad)
				2'd0: begin
					w1.re <= c;
					w1.im <= -s;
				end
				// theta = pi/2 + x
				2'd1: begin
					w1.re <= -s;
					w1.im <= -c;
				end
				// theta = pi + x
				2'd2: begin
					w1.re <= -c;
					w1.im <= s;
				end
				// theta = 3pi/2 + x
				default: begin
					w1.re <= s;
					w1.im <= c;
				end
			endcase
		end
	end

endmodule

/* twdl_delay.sv */
`timescale 1ns/1ps

module twdl_delay #(
	parameter type payload_t = logic,
	parameter int  depth = 1
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t d,
	output payload_t q
);

	payload_t sr [depth];

	// plain shift, stage 0 takes the input
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++)
				sr[i] <= '0;
		end else begin
			sr[0] <= d;
			for (int i = 1; i < depth; i++)
				sr[i] <= sr[i-1];
		end
	end

	assign q = sr[depth-1];

endmodule

/* twdl_pkg.sv */
package twdl_pkg;

	// data path width, signed
	localparam int data_w = 18;
	// twiddle width, Q2.14 so one is 16384
	localparam int tw_w = 16;
	// 256 phase steps per turn
	localparam int phase_w = 8;
	// points per beat, enough for radix 5
	localparam int n_pts = 5;
	// input beat to output beat
	localparam int pipe_lat = 7;
	// accumulator width for rounded products
	localparam int prod_w = 40;

	// one complex data point
	typedef struct packed {
		logic signed [data_w-1:0] re;
		logic signed [data_w-1:0] im;
	} cplx_t;

	// one complex twiddle
	typedef struct packed {
		logic signed [tw_w-1:0] re;
		logic signed [tw_w-1:0] im;
	} tw_t;

	// index k holds point k
	typedef cplx_t [n_pts-1:0] pts_t;
	// index 0 is w1, index 3 is w4
	typedef tw_t [3:0] tws_t;

	// radix 2..5, inverse selects conjugate twiddles
	typedef struct packed {
		logic [2:0] radix;
		logic       inverse;
	} cfg_t;

	// drop 14 fraction bits, round half up via bit 13
	function automatic logic signed [prod_w-15:0] round_q14(input logic signed [prod_w-1:0] v);
		return $signed(v[prod_w-1:14]) + $signed({{(prod_w-15){1'b0}}, v[13]});
	endfunction

endpackage

/* twdl_power_pipe.sv */
`timescale 1ns/1ps

module twdl_power_pipe import twdl_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  tw_t  w1,
	input  cfg_t cfg,
	output tws_t tws
);

	// one in Q2.14
	localparam tw_t tw_one = '{re: tw_w'(1 << 14), im: '0};

	// rounded complex product of two twiddles
	function automatic tw_t tw_mul(input tw_t a, input tw_t b);
		logic signed [prod_w-1:0]  acc_re;
		logic signed [prod_w-1:0]  acc_im;
		logic signed [prod_w-15:0] rnd_re;
		logic signed [prod_w-15:0] rnd_im;
		tw_t                       r;
		acc_re = a.re * b.re - a.im * b.im;
		acc_im = a.re * b.im + a.im * b.re;
		rnd_re = round_q14(acc_re);
		rnd_im = round_q14(acc_im);
		// back to Q2.14
		r.re = rnd_re[tw_w-1:0];
		r.im = rnd_im[tw_w-1:0];
		return r;
	endfunction

	tw_t w1_s1;
	tw_t w1_s2;
	tw_t w2_s2;

	// stage 1: conjugate for inverse transform
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w1_s1 <= '0;
		end else begin
			w1_s1.re <= w1.re;
			w1_s1.im <= cfg.inverse ? -w1.im : w1.im;
		end
	end

	// stage 2: square, w1 carried along
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w1_s2 <= '0;
			w2_s2 <= '0;
		end else begin
			w1_s2 <= w1_s1;
			// radix 2 has no second power
			if (cfg.radix == 3'd2)
				w2_s2 <= tw_one;
			else
				w2_s2 <= tw_mul(w1_s1, w1_s1);
		end
	end

	// stage 3: cube and fourth power
	// w1, w2 delayed one more so all four line up
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tws <= '0;
		end else begin
			tws[0] <= w1_s2;
			tws[1] <= w2_s2;
			tws[2] <= tw_mul(w1_s2, w2_s2);
			tws[3] <= tw_mul(w2_s2, w2_s2);
		end
	end

endmodule

/* twdl_rom.hex */
// quarter-wave cosine table, cos(2*pi*i/256) for i from 0 to 64
// one Q2.14 word per line with 4000 as one
4000
3FFB
3FEC
3FD4
3FB1
3F85
3F4F
3F0F
3EC5
3E72
3E15
3DAF
3D3F
3CC5
3C42
3BB6
3B21
3A82
39DB
392B
3871
37B0
36E5
3612
3537
3453
3368
3274
3179
3076
2F6C
2E5A
2D41
2C21
2AFB
29CE
289A
2760
2620
24DA
238E
223D
20E7
1F8C
1E2B
1CC6
1B5D
19EF
187E
1709
1590
1413
1294
1112
0F8D
0E06
0C7C
0AF1
0964
07D6
0646
04B5
0324
0192
0000

/* twdl_stage.f */
twdl_pkg.sv
twdl_cfg_regs.sv
twdl_coeff_gen.sv
twdl_power_pipe.sv
twdl_cmult.sv
twdl_delay.sv
twdl_stage.sv
twdl_stage_tb.sv

/* twdl_stage.sv */
`timescale 1ns/1ps

module twdl_stage import twdl_pkg::*; #(
	parameter int data_w = twdl_pkg::data_w,
	parameter int phase_w = twdl_pkg::phase_w
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_val,
	input  pts_t               din,
	input  logic [phase_w-1:0] phase,
	input  logic               cfg_wr,
	input  cfg_t               cfg_in,
	output logic               out_val,
	output pts_t               dout,
	output logic               cfg_err
);

	cfg_t                cfg;
	tw_t                 w1;
	tws_t                tws;
	pts_t                din_d;
	cplx_t               p0_d;
	pts_t                lane_y;
	logic [pipe_lat-1:0] val_sr;

	twdl_cfg_regs u_cfg (
		.clk    (clk),
		.rst_n  (rst_n),
		.cfg_wr (cfg_wr),
		.cfg_in (cfg_in),
		.cfg    (cfg),
		.cfg_err(cfg_err)
	);

	// phase to w1, 2 cycles
	twdl_coeff_gen #(.phase_w(phase_w)) u_coeff (
		.clk  (clk),
		.rst_n(rst_n),
		.phase(phase),
		.w1   (w1)
	);

	// w1 to w1..w4, 3 cycles
	twdl_power_pipe u_pow (
		.clk  (clk),
		.rst_n(rst_n),
		.w1   (w1),
		.cfg  (cfg),
		.tws  (tws)
	);

	// points wait 5 cycles for their twiddles
	twdl_delay #(.payload_t(pts_t), .depth(pipe_lat - 2)) u_dly_pts (
		.clk  (clk),
		.rst_n(rst_n),
		.d    (din),
		.q    (din_d)
	);

	// point 0 bypasses the multipliers
	twdl_delay #(.payload_t(cplx_t), .depth(pipe_lat)) u_dly_p0 (
		.clk  (clk),
		.rst_n(rst_n),
		.d    (din[0]),
		.q    (p0_d)
	);

	assign lane_y[0] = p0_d;

	// point k times w1^k
	for (genvar k = 1; k < n_pts; k++) begin : g_lane
		twdl_cmult #(.data_w(data_w)) u_cmult (
			.clk  (clk),
			.rst_n(rst_n),
			.x    (din_d[k]),
			.w    (tws[k-1]),
			.y    (lane_y[k])
		);
	end

	// valid tracks the beat through all stages
	always_ff @(posedge clk) begin
		if (!rst_n)
			val_sr <= '0;
		else
			val_sr <= {val_sr[pipe_lat-2:0], in_val};
	end

	assign out_val = val_sr[pipe_lat-1];

	// lanes at or above radix read zero, idle output too
	always_comb begin
		for (int k = 0; k < n_pts; k++) begin
			if (out_val && k < int'(cfg.radix))
				dout[k] = lane_y[k];
			else
				dout[k] = '0;
		end
	end

endmodule

/* twdl_stage_tb.sv */
`timescale 1ns/1ps

module twdl_stage_tb import twdl_pkg::*; ();

	localparam int clk_period = 40;
	// idle cycles allowed between random beats
	localparam int max_gap = 2;
	localparam int n_r4 = 200;
	localparam int n_r35 = 100;
	localparam int n_r2 = 100;
	localparam int n_inv = 100;
	localparam int n_rot = 16;
	localparam int n_bad = 10;
	localparam int total_beats = n_r4 + 2 * n_r35 + n_r2 + n_inv + n_rot + 5 * n_bad;
	// each beat uses at most max_gap + 1 cycles, doubled, plus slack for drains
	localparam longint watchdog_ns =
		2 * total_beats * (max_gap + 1) * clk_period + 2000 * clk_period;

	// wide complex for the reference arithmetic
	typedef struct packed {
		longint re;
		longint im;
	} lcplx_t;

	// expected output and the cycle it went in
	typedef struct packed {
		pts_t   pts;
		longint sent;
	} beat_t;

	logic               clk;
	logic               rst_n;
	logic               in_val;
	pts_t               din;
	logic [phase_w-1:0] phase;
	logic               cfg_wr;
	cfg_t               cfg_in;
	logic               out_val;
	pts_t               dout;
	logic               cfg_err;

	logic signed [tw_w-1:0] tab [0:64];
	beat_t                  exp_q [$];
	beat_t                  mon_beat;
	longint                 cyc;
	integer                 seed;
	int                     checks;
	int                     errors;
	int                     test_errs;
	// configuration as the testbench expects it
	logic [2:0]             mdl_radix;
	logic                   mdl_inverse;
	logic                   mdl_err;

	twdl_stage #(.data_w(data_w), .phase_w(phase_w)) dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.in_val (in_val),
		.din    (din),
		.phase  (phase),
		.cfg_wr (cfg_wr),
		.cfg_in (cfg_in),
		.out_val(out_val),
		.dout   (dout),
		.cfg_err(cfg_err)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// cycle count read on falling edges
	initial cyc = 0;
	always @(posedge clk) cyc <= cyc + 1;

	// keep the low w bits as a signed value
	function automatic longint sign_wrap(input longint v, input int w);
		longint m;
		longint r;
		m = (longint'(1) <<< w) - 1;
		r = v & m;
		if (r >= (longint'(1) <<< (w - 1)))
			r = r - (longint'(1) <<< w);
		return r;
	endfunction

	// half an lsb up, then floor
	function automatic longint round_half_up(input longint v);
		return (v + 8192) >>> 14;
	endfunction

	// a times Q2.14 b, rounded and wrapped to w bits
	function automatic lcplx_t cplx_product(input lcplx_t a, input lcplx_t b, input int w);
		lcplx_t r;
		r.re = sign_wrap(round_half_up(a.re * b.re - a.im * b.im), w);
		r.im = sign_wrap(round_half_up(a.re * b.im + a.im * b.re), w);
		return r;
	endfunction

	// w1 = cos - j*sin of 2*pi*ph/256 from the quarter table
	function automatic lcplx_t base_twiddle(input logic [phase_w-1:0] ph);
		int     off;
		longint c;
		longint s;
		lcplx_t w;
		off = int'(ph[5:0]);
		c = longint'(tab[off]);
		s = longint'(tab[64 - off]);
		case (ph[7:6])
			2'd0: begin
				w.re = c;
				w.im = -s;
			end
			// cos goes to -sin, sin to cos
			2'd1: begin
				w.re = -s;
				w.im = -c;
			end
			2'd2: begin
				w.re = -c;
				w.im = s;
			end
			default: begin
				w.re = s;
				w.im = c;
			end
		endcase
		return w;
	endfunction

	// reference output of one beat
	function automatic pts_t expected_points(input pts_t x, input logic [phase_w-1:0] ph,
			input logic [2:0] radix, input logic inv);
		lcplx_t tw [1:4];
		lcplx_t one;
		lcplx_t xp;
		lcplx_t y;
		pts_t   r;
		int     k;
		one.re = 16384;
		one.im = 0;
		tw[1] = base_twiddle(ph);
		if (inv)
			tw[1].im = -tw[1].im;
		if (radix == 3'd2)
			tw[2] = one;
		else
			tw[2] = cplx_product(tw[1], tw[1], tw_w);
		tw[3] = cplx_product(tw[1], tw[2], tw_w);
		tw[4] = cplx_product(tw[2], tw[2], tw_w);
		r = '0;
		r[0] = x[0];
		for (k = 1; k < n_pts; k++) begin
			xp.re = longint'(x[k].re);
			xp.im = longint'(x[k].im);
			y = cplx_product(xp, tw[k], data_w);
			r[k].re = data_w'(y.re);
			r[k].im = data_w'(y.im);
		end
		// lanes past the radix are unused
		for (k = 0; k < n_pts; k++) begin
			if (k >= int'(radix))
				r[k] = '0;
		end
		return r;
	endfunction

	// lane k turned exactly by j^(q*k)
	function automatic pts_t rotated_points(input pts_t x, input int q, input logic [2:0] radix);
		pts_t                     r;
		cplx_t                    p;
		logic signed [data_w-1:0] t;
		int                       k;
		int                       n;
		r = '0;
		for (k = 0; k < n_pts; k++) begin
			p = x[k];
			for (n = 0; n < (q * k) % 4; n++) begin
				// times j
				t = p.re;
				p.re = -p.im;
				p.im = t;
			end
			if (k < int'(radix))
				r[k] = p;
		end
		return r;
	endfunction

	// random points inside +-2^16 so rotation cannot overflow
	function automatic pts_t rand_points();
		pts_t r;
		int   k;
		for (k = 0; k < n_pts; k++) begin
			r[k].re = data_w'($random(seed) % 65536);
			r[k].im = data_w'($random(seed) % 65536);
		end
		return r;
	endfunction

	task automatic check_val(input string name, input longint got, input longint exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_lanes(input pts_t got, input pts_t exp);
		int k;
		for (k = 0; k < n_pts; k++) begin
			check_val($sformatf("dout[%0d].re", k), longint'(got[k].re), longint'(exp[k].re));
			check_val($sformatf("dout[%0d].im", k), longint'(got[k].im), longint'(exp[k].im));
		end
	endtask

	task automatic send_beat(input pts_t x, input logic [phase_w-1:0] ph, input pts_t exp);
		beat_t b;
		@(negedge clk);
		in_val = 1'b1;
		din = x;
		phase = ph;
		b.pts = exp;
		b.sent = cyc;
		exp_q.push_back(b);
	endtask

	// junk on din and phase while in_val is low
	task automatic idle_cycle();
		@(negedge clk);
		in_val = 1'b0;
		din = rand_points();
		phase = phase_w'($random(seed));
	endtask

	// wait until every beat in flight has come out
	task automatic drain();
		idle_cycle();
		while (exp_q.size() != 0)
			idle_cycle();
		repeat (2)
			idle_cycle();
		// error flag holds until the next good write
		check_val("cfg_err", longint'(cfg_err), longint'(mdl_err));
	endtask

	task automatic run_random(input int n);
		pts_t               x;
		logic [phase_w-1:0] ph;
		int                 gap;
		int                 i;
		for (i = 0; i < n; i++) begin
			x = rand_points();
			ph = phase_w'($random(seed));
			send_beat(x, ph, expected_points(x, ph, mdl_radix, mdl_inverse));
			gap = {$random(seed)} % (max_gap + 1);
			repeat (gap)
				idle_cycle();
		end
		drain();
	endtask

	// one write, then cfg_err after the edge
	task automatic write_cfg(input logic [2:0] radix, input logic inv);
		@(negedge clk);
		in_val = 1'b0;
		cfg_wr = 1'b1;
		cfg_in.radix = radix;
		cfg_in.inverse = inv;
		if (radix >= 3'd2 && radix <= 3'd5) begin
			mdl_radix = radix;
			mdl_inverse = inv;
			mdl_err = 1'b0;
		end else begin
			mdl_err = 1'b1;
		end
		@(negedge clk);
		cfg_wr = 1'b0;
		check_val("cfg_err", longint'(cfg_err), longint'(mdl_err));
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errs);
		test_errs = errors;
	endtask

	// scoreboard pops one expected beat per out_val
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_val) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("out_val went high at %0d ns with no beat in flight", $time);
				end else begin
					mon_beat = exp_q.pop_front();
					check_val("out_val latency", cyc - mon_beat.sent, longint'(pipe_lat));
					check_lanes(dout, mon_beat.pts);
				end
			end else begin
				// idle output reads zero
				check_lanes(dout, '0);
				if (exp_q.size() != 0 && exp_q[0].sent + pipe_lat <= cyc) begin
					errors++;
					$display("beat sent in cycle %0d did not come out by %0d ns",
						exp_q[0].sent, $time);
					mon_beat = exp_q.pop_front();
				end
			end
		end
	end

	initial begin
		pts_t x;
		int   q;
		int   i;
		int   b;
		seed = 32'hb6f6;
		checks = 0;
		errors = 0;
		test_errs = 0;
		rst_n = 1'b0;
		in_val = 1'b0;
		din = '0;
		phase = '0;
		cfg_wr = 1'b0;
		cfg_in.radix = 3'd4;
		cfg_in.inverse = 1'b0;
		mdl_radix = 3'd4;
		mdl_inverse = 1'b0;
		mdl_err = 1'b0;
		$readmemh("twdl_rom.hex", tab);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// quiet outputs after reset
		@(negedge clk);
		check_val("out_val", longint'(out_val), 0);
		check_val("cfg_err", longint'(cfg_err), 0);
		check_lanes(dout, '0);
		finish_test("reset");

		// reset default is radix 4 forward
		run_random(n_r4);
		finish_test("radix 4 forward");

		write_cfg(3'd3, 1'b0);
		run_random(n_r35);
		write_cfg(3'd5, 1'b0);
		run_random(n_r35);
		finish_test("radix 3 and 5");

		write_cfg(3'd2, 1'b0);
		run_random(n_r2);
		finish_test("radix 2");

		write_cfg(3'd5, 1'b1);
		run_random(n_inv);
		// quarter-turn phases rotate by j^k exactly
		write_cfg(3'd4, 1'b1);
		for (q = 0; q < 4; q++) begin
			for (i = 0; i < n_rot / 4; i++) begin
				x = rand_points();
				send_beat(x, phase_w'(q * 64), rotated_points(x, q, mdl_radix));
			end
		end
		drain();
		finish_test("inverse");

		// radix 0, 1, 6, 7 refused with inverse set, radix 3 forward stays
		write_cfg(3'd3, 1'b0);
		for (b = 0; b < 4; b++) begin
			write_cfg(3'(b < 2 ? b : b + 4), 1'b1);
			run_random(n_bad);
		end
		write_cfg(3'd4, 1'b0);
		run_random(n_bad);
		finish_test("refused config");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired at %0d ns, the run did not finish", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule
